/* widthconv_pkg.sv */
`default_nettype none

package widthconv_pkg;

   // word memory and APB data width
   localparam int word_w = 32;

   // words packed per output beat
   localparam int words_per_beat = 16;

   localparam int beat_w = word_w * words_per_beat;

   typedef logic [word_w-1:0] word_t;

   // word k of a beat sits at bits 32k upward
   typedef logic [beat_w-1:0] beat_t;

   // control register, bit 0 requests a start
   localparam logic [31:0] ctrl_offset = 32'h0000_0000;

   // status register
   // bit 0 busy, bits 15:8 completed packets mod 256
   localparam logic [31:0] status_offset = 32'h0000_0004;

   // word memory window, word i at mem_base + 4i
   localparam logic [31:0] mem_base = 32'h0000_1000;

endpackage

`default_nettype wire

/* simple_dualportram.sv */
`timescale 1ns/10ps
`default_nettype none

module simple_dualportram #(
   parameter type payload_t = logic [31:0],
   parameter int depth = 16
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire [$clog2(depth)-1:0]   waddress,
   input  wire payload_t             din,
   input  wire                       we,
   input  wire [$clog2(depth)-1:0]   raddress,
   output payload_t                  dout
);

   payload_t mem [depth];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddress] <= din;
      end
   end

   // registered read, one cycle from address to data
   always_ff @(posedge clk) begin
      if (reset) begin
         dout <= '0;
      end else begin
         dout <= mem[raddress];
      end
   end

   a_addr_in_range : assert property (@(posedge clk) disable iff (reset)
      we |-> ((int'(waddress) < depth) && (int'(raddress) < depth)));

endmodule

`default_nettype wire

/* conv_counters.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_counters #(
   parameter int num_beats = 32
) (
   input  wire  clk,
   input  wire  reset,
   input  wire  clear,
   input  wire  word_step,
   input  wire  drain_step,
   output logic [$clog2(num_beats*widthconv_pkg::words_per_beat)-1:0] word_count,
   output logic word_last,
   output logic beat_full,
   output logic [$clog2(num_beats)-1:0] beat_index,
   output logic [$clog2(num_beats)-1:0] drain_index,
   output logic drain_last
);
   import widthconv_pkg::*;

   localparam int total_words = num_beats * words_per_beat;
   localparam int lane_w = $clog2(words_per_beat);
   localparam int beat_aw = $clog2(num_beats);

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         word_count <= '0;
         drain_index <= '0;
      end else begin
         if (word_step) begin
            word_count <= word_count + 1'b1;
         end
         if (drain_step) begin
            drain_index <= drain_last ? '0 : drain_index + 1'b1;
         end
      end
   end

   // flags describe the word arriving this cycle
   assign beat_full = (word_count[lane_w-1:0] == lane_w'(words_per_beat - 1));
   assign word_last = (int'(word_count) == total_words - 1);
   assign beat_index = beat_aw'(word_count >> lane_w);
   assign drain_last = (int'(drain_index) == num_beats - 1);

   a_no_step_on_clear : assert property (@(posedge clk) disable iff (reset)
      clear |-> !(word_step || drain_step));

endmodule

`default_nettype wire

/* word_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module word_packer (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  word_valid,
   input  wire widthconv_pkg::word_t data_q,
   input  wire                  beat_full,
   output widthconv_pkg::beat_t beat,
   output logic                 beat_we
);
   import widthconv_pkg::*;

   // holds the first 15 words of a beat
   localparam int hold_w = beat_w - word_w;

   logic [hold_w-1:0] hold;

   // new words enter at the top and move down
   always_ff @(posedge clk) begin
      if (reset) begin
         hold <= '0;
      end else if (word_valid) begin
         hold <= {data_q, hold[hold_w-1:word_w]};
      end
   end

   // 16th word completes the beat in the same cycle
   assign beat = {data_q, hold};
   assign beat_we = word_valid && beat_full;

endmodule

`default_nettype wire

/* conv_control.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_control #(
   parameter int num_beats = 32
) (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          start,
   input  wire                          word_last,
   input  wire                          drain_last,
   input  wire [$clog2(num_beats)-1:0]  drain_index,
   output logic [31:0]                  data_addr,
   output logic                         data_oe,
   output logic                         word_step,
   output logic                         clear,
   output logic                         drain_step,
   output logic [$clog2(num_beats)-1:0] buf_raddr,
   output logic                         src_valid,
   output logic                         src_sop,
   output logic                         src_eop,
   output logic                         busy
);
   import widthconv_pkg::*;

   // byte address of the final word read
   localparam logic [31:0] last_addr = 32'((num_beats * words_per_beat - 1) * (word_w / 8));

   typedef enum logic [2:0] {
      st_idle,
      st_prime,
      st_fill,
      st_lead,
      st_drain
   } state_t;

   state_t state;

   assign clear = (state == st_idle);
   // a word arrives on every fill cycle
   assign word_step = (state == st_fill);
   assign drain_step = (state == st_lead) || (state == st_drain);
   assign buf_raddr = drain_index;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
         data_addr <= '0;
         data_oe <= 1'b0;
         src_valid <= 1'b0;
         src_sop <= 1'b0;
         src_eop <= 1'b0;
         busy <= 1'b0;
      end else begin
         // flags trail the buffer read by one cycle
         src_valid <= drain_step;
         src_sop <= (state == st_lead);
         src_eop <= drain_step && drain_last;
         if (src_eop) begin
            busy <= 1'b0;
         end
         case (state)
            st_idle: begin
               if (start && !busy) begin
                  state <= st_prime;
                  busy <= 1'b1;
                  data_oe <= 1'b1;
                  data_addr <= '0;
               end
            end
            st_prime: begin
               state <= st_fill;
               data_addr <= data_addr + 32'd4;
            end
            st_fill: begin
               if (data_oe) begin
                  if (data_addr == last_addr) begin
                     data_oe <= 1'b0;
                  end else begin
                     data_addr <= data_addr + 32'd4;
                  end
               end
               if (word_last) begin
                  state <= st_lead;
               end
            end
            st_lead: begin
               state <= drain_last ? st_idle : st_drain;
            end
            default: begin
               if (drain_last) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   a_sop_eop_apart : assert property (@(posedge clk) disable iff (reset)
      (src_sop && src_eop) |-> (num_beats == 1));

endmodule

`default_nettype wire

/* datawidthconv_32_to_512.sv */
`timescale 1ns/10ps
`default_nettype none

module datawidthconv_32_to_512 #(
   parameter int num_beats = 32
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  start,
   output logic [31:0]          data_addr,
   output logic                 data_oe,
   input  wire widthconv_pkg::word_t data_q,
   output logic                 src_valid,
   output logic                 src_sop,
   output logic                 src_eop,
   output widthconv_pkg::beat_t src_q,
   output logic                 busy
);
   import widthconv_pkg::*;

   localparam int beat_aw = $clog2(num_beats);
   localparam int word_aw = $clog2(num_beats * words_per_beat);

   logic               word_valid;
   logic               word_step;
   logic               clear;
   logic               drain_step;
   logic [word_aw-1:0] word_count;
   logic               word_last;
   logic               beat_full;
   logic [beat_aw-1:0] beat_index;
   logic [beat_aw-1:0] drain_index;
   logic               drain_last;
   logic [beat_aw-1:0] buf_raddr;
   beat_t              beat;
   logic               beat_we;

   // memory data lands one cycle after data_oe
   always_ff @(posedge clk) begin
      if (reset) begin
         word_valid <= 1'b0;
      end else begin
         word_valid <= data_oe;
      end
   end

   conv_control #(
      .num_beats(num_beats)
   ) i_conv_control (
      .clk(clk),
      .reset(reset),
      .start(start),
      .word_last(word_last),
      .drain_last(drain_last),
      .drain_index(drain_index),
      .data_addr(data_addr),
      .data_oe(data_oe),
      .word_step(word_step),
      .clear(clear),
      .drain_step(drain_step),
      .buf_raddr(buf_raddr),
      .src_valid(src_valid),
      .src_sop(src_sop),
      .src_eop(src_eop),
      .busy(busy)
   );

   conv_counters #(
      .num_beats(num_beats)
   ) i_conv_counters (
      .clk(clk),
      .reset(reset),
      .clear(clear),
      .word_step(word_step),
      .drain_step(drain_step),
      .word_count(word_count),
      .word_last(word_last),
      .beat_full(beat_full),
      .beat_index(beat_index),
      .drain_index(drain_index),
      .drain_last(drain_last)
   );

   word_packer i_word_packer (
      .clk(clk),
      .reset(reset),
      .word_valid(word_valid),
      .data_q(data_q),
      .beat_full(beat_full),
      .beat(beat),
      .beat_we(beat_we)
   );

   simple_dualportram #(
      .payload_t(beat_t),
      .depth(num_beats)
   ) i_beat_buffer (
      .clk(clk),
      .reset(reset),
      .waddress(beat_index),
      .din(beat),
      .we(beat_we),
      .raddress(buf_raddr),
      .dout(src_q)
   );

   // arriving word index matches the address read a cycle earlier
   a_word_order : assert property (@(posedge clk) disable iff (reset)
      word_valid |-> (word_step && (32'(word_count) == ($past(data_addr) >> 2))));

endmodule

`default_nettype wire

/* apb_word_loader.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_word_loader #(
   parameter int num_beats = 32
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire [31:0]           paddr,
   input  wire widthconv_pkg::word_t pwdata,
   output widthconv_pkg::word_t prdata,
   output logic                 pready,
   output logic                 pslverr,
   output logic [$clog2(num_beats*widthconv_pkg::words_per_beat)-1:0] mem_waddr,
   output widthconv_pkg::word_t mem_din,
   output logic                 mem_we,
   output logic [$clog2(num_beats*widthconv_pkg::words_per_beat)-1:0] mem_raddr,
   input  wire widthconv_pkg::word_t mem_dout,
   input  wire                  busy,
   output logic                 start
);
   import widthconv_pkg::*;

   localparam int mem_words = num_beats * words_per_beat;
   localparam int mem_aw = $clog2(mem_words);

   logic        access;
   logic        is_ctrl;
   logic        is_status;
   logic        is_mem;
   logic [31:0] mem_offset;
   logic [7:0]  pkt_count;
   logic        busy_d;

   assign access = psel && penable;
   assign mem_offset = paddr - mem_base;
   assign is_ctrl = (paddr == ctrl_offset);
   assign is_status = (paddr == status_offset);
   assign is_mem = (paddr >= mem_base) && (mem_offset < 32'(mem_words * 4))
                   && (paddr[1:0] == 2'b00);

   // address goes to the RAM in setup, data is back for access
   assign mem_raddr = mem_offset[mem_aw+1:2];
   assign mem_waddr = mem_offset[mem_aw+1:2];
   assign mem_din = pwdata;
   assign mem_we = access && pwrite && is_mem && !busy;

   assign pready = 1'b1;
   assign pslverr = access && (!(is_ctrl || is_status || is_mem)
                               || (is_status && pwrite) || (is_mem && busy));

   always_comb begin
      prdata = '0;
      if (access && !pwrite) begin
         if (is_status) begin
            prdata = {16'h0000, pkt_count, 7'h00, busy};
         end else if (is_mem && !busy) begin
            prdata = mem_dout;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         start <= 1'b0;
         busy_d <= 1'b0;
         pkt_count <= '0;
      end else begin
         start <= access && pwrite && is_ctrl && pwdata[0];
         busy_d <= busy;
         // packet done when busy drops
         if (busy_d && !busy) begin
            pkt_count <= pkt_count + 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* widthconv_top.sv */
`timescale 1ns/10ps
`default_nettype none

module widthconv_top #(
   parameter int num_beats = 32
) (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire [31:0]           paddr,
   input  wire widthconv_pkg::word_t pwdata,
   output widthconv_pkg::word_t prdata,
   output logic                 pready,
   output logic                 pslverr,
   output logic                 src_valid,
   output logic                 src_sop,
   output logic                 src_eop,
   output widthconv_pkg::beat_t src_q
);
   import widthconv_pkg::*;

   localparam int word_depth = num_beats * words_per_beat;
   localparam int word_aw = $clog2(word_depth);

   logic [word_aw-1:0] mem_waddr;
   logic [word_aw-1:0] mem_raddr;
   word_t              mem_din;
   word_t              mem_dout;
   logic               mem_we;
   logic               busy;
   logic               start;
   logic [31:0]        data_addr;
   logic               data_oe;
   word_t              data_q;

   apb_word_loader #(
      .num_beats(num_beats)
   ) i_apb_word_loader (
      .clk(clk),
      .reset(reset),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .paddr(paddr),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr),
      .mem_waddr(mem_waddr),
      .mem_din(mem_din),
      .mem_we(mem_we),
      .mem_raddr(mem_raddr),
      .mem_dout(mem_dout),
      .busy(busy),
      .start(start)
   );

   // two copies written together, one read port each
   simple_dualportram #(
      .payload_t(word_t),
      .depth(word_depth)
   ) i_word_mem_conv (
      .clk(clk),
      .reset(reset),
      .waddress(mem_waddr),
      .din(mem_din),
      .we(mem_we),
      .raddress(data_addr[word_aw+1:2]),
      .dout(data_q)
   );

   simple_dualportram #(
      .payload_t(word_t),
      .depth(word_depth)
   ) i_word_mem_host (
      .clk(clk),
      .reset(reset),
      .waddress(mem_waddr),
      .din(mem_din),
      .we(mem_we),
      .raddress(mem_raddr),
      .dout(mem_dout)
   );

   datawidthconv_32_to_512 #(
      .num_beats(num_beats)
   ) i_datawidthconv (
      .clk(clk),
      .reset(reset),
      .start(start),
      .data_addr(data_addr),
      .data_oe(data_oe),
      .data_q(data_q),
      .src_valid(src_valid),
      .src_sop(src_sop),
      .src_eop(src_eop),
      .src_q(src_q),
      .busy(busy)
   );

endmodule

`default_nettype wire

/* tb_widthconv_checks.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_widthconv_checks #(
   parameter int num_beats = 32
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       src_valid,
   input  wire                       src_sop,
   input  wire                       src_eop,
   input  wire widthconv_pkg::beat_t src_q,
   input  wire                       busy,
   input  wire                       data_oe,
   input  wire                       start,
   input  wire                       pslverr
);
   import widthconv_pkg::*;

   bit   check_failed;
   int   packets_seen;
   int   beat_idx;
   logic in_packet;

   task automatic flag_failure(input string text);
      $error("%s", text);
      check_failed = 1'b1;
   endtask

   // beat k holds model words 16k..16k+15, lowest word first
   function automatic beat_t expected_beat(input int idx);
      beat_t b;
      for (int j = 0; j < words_per_beat; j++) begin
         b[j*word_w +: word_w] = tb_widthconv.model_words[idx*words_per_beat + j];
      end
      return b;
   endfunction

   // stream scoreboard
   always @(posedge clk) begin
      if (reset) begin
         beat_idx <= 0;
         in_packet <= 1'b0;
      end else if (src_valid) begin
         assert (src_q === expected_beat(beat_idx))
         else flag_failure($sformatf("CHECK FAILED src_q beat %0d expected %h actual %h",
                                     beat_idx, expected_beat(beat_idx), src_q));
         assert (src_sop === (beat_idx == 0))
         else flag_failure($sformatf("CHECK FAILED src_sop beat %0d expected %h actual %h",
                                     beat_idx, (beat_idx == 0), src_sop));
         assert (src_eop === (beat_idx == num_beats - 1))
         else flag_failure($sformatf("CHECK FAILED src_eop beat %0d expected %h actual %h",
                                     beat_idx, (beat_idx == num_beats - 1), src_eop));
         if (src_eop) begin
            beat_idx <= 0;
            in_packet <= 1'b0;
            packets_seen <= packets_seen + 1;
         end else begin
            beat_idx <= beat_idx + 1;
            in_packet <= 1'b1;
         end
      end
   end

   a_sop_with_valid : assert property (@(posedge clk) disable iff (reset)
      src_sop |-> src_valid)
      else flag_failure("src_sop was high without src_valid");

   a_eop_with_valid : assert property (@(posedge clk) disable iff (reset)
      src_eop |-> src_valid)
      else flag_failure("src_eop was high without src_valid");

   // no gaps inside a packet
   a_contiguous : assert property (@(posedge clk) disable iff (reset)
      (src_valid && !src_eop) |=> src_valid)
      else flag_failure("src_valid dropped in the middle of a packet");

   a_no_stray_valid : assert property (@(posedge clk) disable iff (reset)
      src_valid |-> (src_sop || in_packet))
      else flag_failure("src_valid was high outside a packet");

   a_busy_covers : assert property (@(posedge clk) disable iff (reset)
      src_valid |-> busy)
      else flag_failure("busy was low while a beat was on the stream");

   a_busy_falls : assert property (@(posedge clk) disable iff (reset)
      src_eop |=> !busy)
      else flag_failure("busy did not fall the cycle after eop");

   a_reset_state : assert property (@(posedge clk)
      $fell(reset) |-> !(src_valid || src_sop || src_eop || data_oe || start || busy || pslverr))
      else flag_failure("outputs were not cleared by reset");

endmodule

`default_nettype wire

/* tb_widthconv.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_widthconv;
   import widthconv_pkg::*;

   localparam int num_beats = 32;
   localparam int mem_words = num_beats * words_per_beat;
   localparam int apb_accesses = 3 * mem_words + 16;
   localparam int timeout_cycles = 3 * (num_beats * 18 + 50) + 4 * apb_accesses + 200;

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   word_t       pwdata;
   word_t       prdata;
   logic        pready;
   logic        pslverr;
   logic        src_valid;
   logic        src_sop;
   logic        src_eop;
   beat_t       src_q;

   word_t       model_words [mem_words];
   bit          check_failed;
   int          cycle_count;

   widthconv_top #(
      .num_beats(num_beats)
   ) i_widthconv_top (
      .clk(clk),
      .reset(reset),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .paddr(paddr),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr),
      .src_valid(src_valid),
      .src_sop(src_sop),
      .src_eop(src_eop),
      .src_q(src_q)
   );

   bind widthconv_top tb_widthconv_checks #(
      .num_beats(num_beats)
   ) i_checks (
      .clk(clk),
      .reset(reset),
      .src_valid(src_valid),
      .src_sop(src_sop),
      .src_eop(src_eop),
      .src_q(src_q),
      .busy(busy),
      .data_oe(data_oe),
      .start(start),
      .pslverr(pslverr)
   );

   always #2 clk = ~clk;

   // setup, access, then one idle cycle
   task automatic apb_access(input logic write, input logic [31:0] addr, input word_t wdata,
                             output word_t rdata, output logic err);
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= write;
      paddr <= addr;
      pwdata <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      rdata = prdata;
      err = pslverr;
      expect_equal("pready", 32'd1, 32'(pready));
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic expect_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         check_failed = 1'b1;
      end
   endtask

   task automatic write_expect(input logic [31:0] addr, input word_t wdata, input logic exp_err);
      word_t rdata;
      logic  err;
      apb_access(1'b1, addr, wdata, rdata, err);
      expect_equal("pslverr", 32'(exp_err), 32'(err));
   endtask

   task automatic read_expect_err(input logic [31:0] addr, input logic exp_err,
                                  output word_t rdata);
      logic err;
      apb_access(1'b0, addr, 32'h0, rdata, err);
      expect_equal("pslverr", 32'(exp_err), 32'(err));
   endtask

   task automatic load_words();
      for (int i = 0; i < mem_words; i++) begin
         model_words[i] = $urandom;
         write_expect(mem_base + 32'(i * 4), model_words[i], 1'b0);
      end
   endtask

   task automatic read_back_words();
      word_t rdata;
      for (int i = 0; i < mem_words; i++) begin
         read_expect_err(mem_base + 32'(i * 4), 1'b0, rdata);
         expect_equal($sformatf("prdata word %0d", i), model_words[i], rdata);
      end
   endtask

   task automatic check_status(input logic exp_busy, input logic [7:0] exp_count);
      word_t rdata;
      read_expect_err(status_offset, 1'b0, rdata);
      expect_equal("status busy", 32'(exp_busy), 32'(rdata[0]));
      expect_equal("status packet count", 32'(exp_count), 32'(rdata[15:8]));
   endtask

   task automatic wait_packet_end();
      @(negedge clk);
      while (!src_eop) begin
         @(negedge clk);
      end
   endtask

   initial begin
      wait (check_failed || i_widthconv_top.i_checks.check_failed);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first failed check");
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAIL");
      $fatal(1, "run stopped by the cycle limit");
   end

   initial begin
      word_t rdata;
      void'($urandom(52400));
      clk = 1'b0;
      reset = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      load_words();
      read_back_words();

      // unmapped and read-only decode
      write_expect(status_offset, 32'h1, 1'b1);
      read_expect_err(32'h0000_0008, 1'b1, rdata);
      write_expect(mem_base + 32'(mem_words * 4), 32'h1, 1'b1);

      // first packet, with a start and memory access while busy
      write_expect(ctrl_offset, 32'h1, 1'b0);
      check_status(1'b1, 8'd0);
      write_expect(ctrl_offset, 32'h1, 1'b0);
      read_expect_err(mem_base, 1'b1, rdata);
      write_expect(mem_base + 32'd4, 32'hdead_beef, 1'b1);
      wait_packet_end();
      check_status(1'b0, 8'd1);
      expect_equal("packets_seen", 32'd1, 32'(i_widthconv_top.i_checks.packets_seen));

      // second packet from fresh data
      load_words();
      write_expect(ctrl_offset, 32'h1, 1'b0);
      check_status(1'b1, 8'd1);
      wait_packet_end();
      check_status(1'b0, 8'd2);
      expect_equal("packets_seen", 32'd2, 32'(i_widthconv_top.i_checks.packets_seen));

      if (check_failed || i_widthconv_top.i_checks.check_failed) begin
         $display("TEST FAIL");
         $fatal(1, "failed checks at the end of the run");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* files.f */
widthconv_pkg.sv
simple_dualportram.sv
conv_counters.sv
word_packer.sv
conv_control.sv
datawidthconv_32_to_512.sv
apb_word_loader.sv
widthconv_top.sv
tb_widthconv_checks.sv
tb_widthconv.sv

/* Bender.yml */
package:
  name: widthconv

sources:
  - widthconv_pkg.sv
  - simple_dualportram.sv
  - conv_counters.sv
  - word_packer.sv
  - conv_control.sv
  - datawidthconv_32_to_512.sv
  - apb_word_loader.sv
  - widthconv_top.sv
  - target: test
    files:
      - tb_widthconv_checks.sv
      - tb_widthconv.sv
